/* common/coreIsaPkg.sv */
`default_nettype none

package coreIsaPkg;

  // Datapath and register index widths
  localparam int WordWidth    = 32;
  localparam int RegAddrWidth = 3;
  localparam int ImmWidth     = 22;

  // Opcodes sit in the top four bits of every instruction word
  typedef enum logic [3:0] {
    OpNop   = 4'd0,
    OpAdd   = 4'd1,
    OpSub   = 4'd2,
    OpAnd   = 4'd3,
    OpOr    = 4'd4,
    OpAddi  = 4'd5,
    OpLoad  = 4'd6,
    OpStore = 4'd7,
    OpBeq   = 4'd8
  } opcodeT;

  // ALU function chosen in decode
  typedef enum logic [1:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr
  } aluOpT;

  // Register-register view
  typedef struct packed {
    opcodeT                  opcode;
    logic [RegAddrWidth-1:0] rd;
    logic [RegAddrWidth-1:0] rs1;
    logic [RegAddrWidth-1:0] rs2;
    logic [18:0]             unused;
  } regFormatT;

  // Register-immediate view, immediate is signed
  // Store takes its data from rd, beq compares rd with rs1
  typedef struct packed {
    opcodeT                  opcode;
    logic [RegAddrWidth-1:0] rd;
    logic [RegAddrWidth-1:0] rs1;
    logic [ImmWidth-1:0]     imm;
  } immFormatT;

  // One instruction word, two decodings
  typedef union packed {
    regFormatT r;
    immFormatT i;
  } instrWordT;

  // Decoded controls carried down the pipeline
  typedef struct packed {
    logic                    regWrite;
    logic                    memToReg;
    logic                    memWrite;
    logic                    branch;
    logic                    useImm;
    aluOpT                   aluOp;
    logic [RegAddrWidth-1:0] dest;
  } ctrlT;

endpackage

`default_nettype wire

/* common/hazardCtlPkg.sv */
`default_nettype none

package hazardCtlPkg;

  // Source of an execute operand
  typedef enum logic [1:0] {
    FwdNone      = 2'b00,
    FwdWriteback = 2'b01,
    FwdMemory    = 2'b10
  } fwdSelT;

  // Everything the hazard unit hands back to the core
  typedef struct packed {
    logic   stallF;
    logic   stallD;
    logic   flushD;
    logic   flushE;
    fwdSelT forwardA;
    fwdSelT forwardB;
  } hazardCtlT;

endpackage

`default_nettype wire

/* hdl/decodeUnit.sv */
`default_nettype none

module decodeUnit
  import coreIsaPkg::*;
(
  input  instrWordT               instr,
  output ctrlT                    ctrl,
  output logic [WordWidth-1:0]    imm,
  output logic [RegAddrWidth-1:0] src1,
  output logic [RegAddrWidth-1:0] src2
);

  logic [WordWidth-1:0] immExt;

  // Sign-extended immediate from the immediate view
  assign immExt = {{(WordWidth - ImmWidth){instr.i.imm[ImmWidth-1]}}, instr.i.imm};

  always_comb
  begin
    // Defaults describe a bubble
    ctrl = '0;
    imm  = '0;
    src1 = instr.r.rs1;
    src2 = '0;
    case (instr.r.opcode)
      OpAdd, OpSub, OpAnd, OpOr:
      begin
        ctrl.regWrite = 1'b1;
        ctrl.dest     = instr.r.rd;
        src2          = instr.r.rs2;
        case (instr.r.opcode)
          OpSub:   ctrl.aluOp = AluSub;
          OpAnd:   ctrl.aluOp = AluAnd;
          OpOr:    ctrl.aluOp = AluOr;
          default: ctrl.aluOp = AluAdd;
        endcase
      end
      OpAddi, OpLoad:
      begin
        // Load computes its address like addi
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = (instr.i.opcode == OpLoad);
        ctrl.useImm   = 1'b1;
        ctrl.aluOp    = AluAdd;
        ctrl.dest     = instr.i.rd;
        imm           = immExt;
      end
      OpStore:
      begin
        // rd names the data source, no destination
        ctrl.memWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        ctrl.aluOp    = AluAdd;
        imm           = immExt;
        src2          = instr.i.rd;
      end
      OpBeq:
      begin
        // Compare rd with rs1, offset in words
        ctrl.branch = 1'b1;
        imm         = immExt;
        src2        = instr.i.rd;
      end
      default:
        // Nop and unused opcodes read nothing
        src1 = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/executeStage.sv */
`default_nettype none

module executeStage
  import coreIsaPkg::*;
  import hazardCtlPkg::*;
(
  input  ctrlT                 ctrlE,
  input  logic [WordWidth-1:0] rd1E,
  input  logic [WordWidth-1:0] rd2E,
  input  logic [WordWidth-1:0] immE,
  input  logic [WordWidth-1:0] pcE,
  input  logic [WordWidth-1:0] aluResultM,
  input  logic [WordWidth-1:0] resultW,
  input  fwdSelT               forwardA,
  input  fwdSelT               forwardB,
  output logic [WordWidth-1:0] aluResultE,
  output logic [WordWidth-1:0] storeDataE,
  output logic [WordWidth-1:0] branchTargetE,
  output logic                 branchTakenE
);

  logic [WordWidth-1:0] srcA;
  logic [WordWidth-1:0] srcB;
  logic [WordWidth-1:0] operandB;

  // Operand source select shared by both ports
  function automatic logic [WordWidth-1:0] fwdMux(
    input fwdSelT               sel,
    input logic [WordWidth-1:0] regVal,
    input logic [WordWidth-1:0] memVal,
    input logic [WordWidth-1:0] wbVal
  );
    case (sel)
      FwdMemory:    return memVal;
      FwdWriteback: return wbVal;
      default:      return regVal;
    endcase
  endfunction

  assign srcA = fwdMux(forwardA, rd1E, aluResultM, resultW);
  assign srcB = fwdMux(forwardB, rd2E, aluResultM, resultW);

  // Immediate replaces the second operand for addi, load and store
  assign operandB = ctrlE.useImm ? immE : srcB;

  always_comb
  begin
    case (ctrlE.aluOp)
      AluSub:  aluResultE = srcA - operandB;
      AluAnd:  aluResultE = srcA & operandB;
      AluOr:   aluResultE = srcA | operandB;
      default: aluResultE = srcA + operandB;
    endcase
  end

  // Store data is the forwarded rd value
  assign storeDataE = srcB;

  // Branch resolves here, target relative to its own word address
  assign branchTakenE  = ctrlE.branch & (srcA == srcB);
  assign branchTargetE = pcE + immE;

endmodule

`default_nettype wire

/* hdl/hazard.sv */
`default_nettype none

module hazard
  import hazardCtlPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      match1EM,
  input  logic      match1EW,
  input  logic      match2EM,
  input  logic      match2EW,
  input  logic      match1DE,
  input  logic      match2DE,
  input  logic      regWriteM,
  input  logic      regWriteW,
  input  logic      memToRegE,
  input  logic      branchTakenE,
  output hazardCtlT ctl
);

  fwdSelT forwardA;
  fwdSelT forwardB;
  logic   loadUseStall;

  // Forwarding, the younger result in memory wins over writeback
  always_comb
  begin
    if (match1EM && regWriteM)
      forwardA = FwdMemory;
    else if (match1EW && regWriteW)
      forwardA = FwdWriteback;
    else
      forwardA = FwdNone;

    if (match2EM && regWriteM)
      forwardB = FwdMemory;
    else if (match2EW && regWriteW)
      forwardB = FwdWriteback;
    else
      forwardB = FwdNone;
  end

  // Load in execute feeding a source in decode
  // A taken branch kills the decode instruction anyway
  assign loadUseStall = (match1DE | match2DE) & memToRegE & ~branchTakenE;

  // Hold fetch and decode, push a bubble into execute
  assign ctl.stallF   = loadUseStall;
  assign ctl.stallD   = loadUseStall;
  // Drop the two wrong-path instructions on a taken branch
  assign ctl.flushD   = branchTakenE;
  assign ctl.flushE   = loadUseStall | branchTakenE;
  assign ctl.forwardA = forwardA;
  assign ctl.forwardB = forwardB;

endmodule

`default_nettype wire

/* hdl/pipelineCore.sv */
`default_nettype none

module pipelineCore
  import coreIsaPkg::*;
  import hazardCtlPkg::*;
#(
  parameter int DataMemWords = 16
)
(
  input  logic                    clk,
  input  logic                    reset,
  output logic [WordWidth-1:0]    pcF,
  input  instrWordT               instrF,
  output logic                    retireValid,
  output logic [RegAddrWidth-1:0] retireDest,
  output logic [WordWidth-1:0]    retireData
);

  localparam int DataAddrWidth = $clog2(DataMemWords);

  // Stage registers, all-zero is a bubble
  typedef struct packed {
    instrWordT            instr;
    logic [WordWidth-1:0] pc;
  } decodeRegT;

  typedef struct packed {
    ctrlT                    ctrl;
    logic [WordWidth-1:0]    rd1;
    logic [WordWidth-1:0]    rd2;
    logic [WordWidth-1:0]    imm;
    logic [WordWidth-1:0]    pc;
    logic [RegAddrWidth-1:0] src1;
    logic [RegAddrWidth-1:0] src2;
  } executeRegT;

  typedef struct packed {
    logic                    regWrite;
    logic                    memToReg;
    logic                    memWrite;
    logic [RegAddrWidth-1:0] dest;
    logic [WordWidth-1:0]    aluResult;
    logic [WordWidth-1:0]    storeData;
  } memoryRegT;

  typedef struct packed {
    logic                    regWrite;
    logic [RegAddrWidth-1:0] dest;
    logic [WordWidth-1:0]    result;
  } writebackRegT;

  decodeRegT    dReg;
  executeRegT   eReg;
  memoryRegT    mReg;
  writebackRegT wReg;

  ctrlT                    ctrlD;
  logic [WordWidth-1:0]    immD;
  logic [RegAddrWidth-1:0] src1D;
  logic [RegAddrWidth-1:0] src2D;
  logic [WordWidth-1:0]    rd1D;
  logic [WordWidth-1:0]    rd2D;
  logic [WordWidth-1:0]    aluResultE;
  logic [WordWidth-1:0]    storeDataE;
  logic [WordWidth-1:0]    branchTargetE;
  logic                    branchTakenE;
  logic [WordWidth-1:0]    resultM;
  logic                    match1EM;
  logic                    match1EW;
  logic                    match2EM;
  logic                    match2EW;
  logic                    match1DE;
  logic                    match2DE;
  hazardCtlT               ctl;

  logic [WordWidth-1:0] dataMem [DataMemWords];

  // Fetch, branch redirect beats the stall
  always_ff @(posedge clk)
  begin
    if (reset)
      pcF <= '0;
    else if (branchTakenE)
      pcF <= branchTargetE;
    else if (!ctl.stallF)
      pcF <= pcF + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset || ctl.flushD)
      dReg <= '0;
    else if (!ctl.stallD)
      dReg <= '{instr: instrF, pc: pcF};
  end

  // Decode
  decodeUnit uDecode (
    .instr (dReg.instr),
    .ctrl  (ctrlD),
    .imm   (immD),
    .src1  (src1D),
    .src2  (src2D)
  );

  // Written from writeback, read in decode
  regFile uRegFile (
    .clk         (clk),
    .reset       (reset),
    .writeEnable (wReg.regWrite),
    .readAddr1   (src1D),
    .readAddr2   (src2D),
    .writeAddr   (wReg.dest),
    .writeData   (wReg.result),
    .readData1   (rd1D),
    .readData2   (rd2D)
  );

  always_ff @(posedge clk)
  begin
    if (reset || ctl.flushE)
      eReg <= '0;
    else
      eReg <= '{ctrl: ctrlD, rd1: rd1D, rd2: rd2D, imm: immD, pc: dReg.pc,
                src1: src1D, src2: src2D};
  end

  // Execute
  executeStage uExecute (
    .ctrlE         (eReg.ctrl),
    .rd1E          (eReg.rd1),
    .rd2E          (eReg.rd2),
    .immE          (eReg.imm),
    .pcE           (eReg.pc),
    .aluResultM    (mReg.aluResult),
    .resultW       (wReg.result),
    .forwardA      (ctl.forwardA),
    .forwardB      (ctl.forwardB),
    .aluResultE    (aluResultE),
    .storeDataE    (storeDataE),
    .branchTargetE (branchTargetE),
    .branchTakenE  (branchTakenE)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
      mReg <= '0;
    else
      mReg <= '{regWrite: eReg.ctrl.regWrite, memToReg: eReg.ctrl.memToReg,
                memWrite: eReg.ctrl.memWrite, dest: eReg.ctrl.dest,
                aluResult: aluResultE, storeData: storeDataE};
  end

  // Memory, low address bits index the words
  always_ff @(posedge clk)
  begin
    if (mReg.memWrite)
      dataMem[mReg.aluResult[DataAddrWidth-1:0]] <= mReg.storeData;
  end

  assign resultM = mReg.memToReg ? dataMem[mReg.aluResult[DataAddrWidth-1:0]]
                                 : mReg.aluResult;

  always_ff @(posedge clk)
  begin
    if (reset)
      wReg <= '0;
    else
      wReg <= '{regWrite: mReg.regWrite, dest: mReg.dest, result: resultM};
  end

  // Register matches, r0 never counts
  assign match1EM = (eReg.src1 != '0) && (eReg.src1 == mReg.dest);
  assign match2EM = (eReg.src2 != '0) && (eReg.src2 == mReg.dest);
  assign match1EW = (eReg.src1 != '0) && (eReg.src1 == wReg.dest);
  assign match2EW = (eReg.src2 != '0) && (eReg.src2 == wReg.dest);
  assign match1DE = (src1D != '0) && (src1D == eReg.ctrl.dest);
  assign match2DE = (src2D != '0) && (src2D == eReg.ctrl.dest);

  hazard uHazard (
    .clk          (clk),
    .reset        (reset),
    .match1EM     (match1EM),
    .match1EW     (match1EW),
    .match2EM     (match2EM),
    .match2EW     (match2EW),
    .match1DE     (match1DE),
    .match2DE     (match2DE),
    .regWriteM    (mReg.regWrite),
    .regWriteW    (wReg.regWrite),
    .memToRegE    (eReg.ctrl.memToReg),
    .branchTakenE (branchTakenE),
    .ctl          (ctl)
  );

  // Retire port mirrors the register file write
  assign retireValid = wReg.regWrite;
  assign retireDest  = wReg.dest;
  assign retireData  = wReg.result;

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile
  import coreIsaPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    writeEnable,
  input  logic [RegAddrWidth-1:0] readAddr1,
  input  logic [RegAddrWidth-1:0] readAddr2,
  input  logic [RegAddrWidth-1:0] writeAddr,
  input  logic [WordWidth-1:0]    writeData,
  output logic [WordWidth-1:0]    readData1,
  output logic [WordWidth-1:0]    readData2
);

  localparam int NumRegs = 1 << RegAddrWidth;

  logic [WordWidth-1:0] regs [NumRegs];

  // r0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NumRegs; i++)
        regs[i] <= '0;
    end
    else if (writeEnable && (writeAddr != '0))
      regs[writeAddr] <= writeData;
  end

  // Same-cycle write passes straight through to the reader
  function automatic logic [WordWidth-1:0] readPort(input logic [RegAddrWidth-1:0] addr);
    if (addr == '0)
      return '0;
    else if (writeEnable && (writeAddr == addr))
      return writeData;
    else
      return regs[addr];
  endfunction

  assign readData1 = readPort(readAddr1);
  assign readData2 = readPort(readAddr2);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module pipelineCore_tb -f sources.f -o simv

./obj_dir/simv | tee sim.log

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
  exit 0
else
  exit 1
fi

/* sources.f */
common/coreIsaPkg.sv
common/hazardCtlPkg.sv
hdl/hazard.sv
hdl/regFile.sv
hdl/decodeUnit.sv
hdl/executeStage.sv
hdl/pipelineCore.sv
testbench/pipelineCore_assertions.sv
testbench/pipelineCore_tb.sv

/* testbench/pipelineCore_assertions.sv */
`default_nettype none

module pipelineCore_assertions
  import hazardCtlPkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      branchTakenE,
  input hazardCtlT ctl
);

  timeunit 1ns;
  timeprecision 100ps;

  // A decode stall always leaves a bubble in execute
  stallFlushesExecute: assert property (
    @(posedge clk) disable iff (reset) ctl.stallD |-> ctl.flushE
  ) else $error("stallD raised without flushE");

  // Decode is only flushed by a taken branch
  decodeFlushOnBranch: assert property (
    @(posedge clk) disable iff (reset) ctl.flushD |-> branchTakenE
  ) else $error("flushD raised without a taken branch");

  // Bubbles everywhere after reset, so no control may be active
  quietAfterReset: assert property (
    @(posedge clk) reset |=> (ctl == '0)
  ) else $error("hazard control active in the cycle after reset");

endmodule

`default_nettype wire

/* testbench/pipelineCore_tb.sv */
`default_nettype none

module pipelineCore_tb
  import coreIsaPkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MaxRows    = 64;
  localparam int MaxRetires = 128;

  logic                    clk;
  logic                    reset;
  logic [WordWidth-1:0]    pcF;
  instrWordT               instrF;
  logic                    retireValid;
  logic [RegAddrWidth-1:0] retireDest;
  logic [WordWidth-1:0]    retireData;

  // Program table, one test name per row
  instrWordT progMem [MaxRows];
  string     progName [MaxRows];
  int        progLen;
  bit        tableReady;

  // Expected retires in program order
  logic [RegAddrWidth-1:0] expDest [MaxRetires];
  logic [WordWidth-1:0]    expData [MaxRetires];
  string                   expName [MaxRetires];
  int                      expCount;

  int checkErrors;
  int otherErrors;
  int seed;

  pipelineCore #(
    .DataMemWords (16)
  ) DUT (
    .clk         (clk),
    .reset       (reset),
    .pcF         (pcF),
    .instrF      (instrF),
    .retireValid (retireValid),
    .retireDest  (retireDest),
    .retireData  (retireData)
  );

  bind pipelineCore pipelineCore_assertions uAssertions (
    .clk          (clk),
    .reset        (reset),
    .branchTakenE (branchTakenE),
    .ctl          (ctl)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic instrWordT regInstr(input opcodeT op, input int rd, input int rs1,
                                         input int rs2);
    instrWordT w;
    w          = '0;
    w.r.opcode = op;
    w.r.rd     = rd[2:0];
    w.r.rs1    = rs1[2:0];
    w.r.rs2    = rs2[2:0];
    return w;
  endfunction

  function automatic instrWordT immInstr(input opcodeT op, input int rd, input int rs1,
                                         input int imm);
    instrWordT w;
    w          = '0;
    w.i.opcode = op;
    w.i.rd     = rd[2:0];
    w.i.rs1    = rs1[2:0];
    w.i.imm    = imm[21:0];
    return w;
  endfunction

  task automatic addRow(input instrWordT word, input string name);
    progMem[progLen]  = word;
    progName[progLen] = name;
    progLen++;
  endtask

  task automatic expectRetire(input logic [2:0] dest, input logic [31:0] value,
                              input string name);
    expDest[expCount] = dest;
    expData[expCount] = value;
    expName[expCount] = name;
    expCount++;
  endtask

  // Instruction memory, nop past the end of the program
  function automatic instrWordT fetchWord(input logic [WordWidth-1:0] addr);
    if (addr < progLen)
      return progMem[addr];
    else
      return '0;
  endfunction

  // Architectural model, one instruction at a time in program order
  task automatic runReferenceModel();
    logic [31:0] regs [8];
    logic [31:0] mem [16];
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] immV;
    logic [31:0] addr;
    logic [31:0] result;
    logic [2:0]  rd;
    logic        writes;
    opcodeT      op;
    int          pc;
    int          nextPc;
    int          steps;
    for (int k = 0; k < 8; k++)
      regs[k] = '0;
    for (int k = 0; k < 16; k++)
      mem[k] = '0;
    pc    = 0;
    steps = 0;
    while (pc < progLen && steps < 1000)
    begin
      word   = progMem[pc];
      op     = opcodeT'(word[31:28]);
      rd     = word[27:25];
      a      = regs[word[24:22]];
      b      = regs[word[21:19]];
      d      = regs[rd];
      immV   = {{10{word[21]}}, word[21:0]};
      addr   = a + immV;
      writes = 1'b1;
      result = '0;
      nextPc = pc + 1;
      case (op)
        OpAdd:   result = a + b;
        OpSub:   result = a - b;
        OpAnd:   result = a & b;
        OpOr:    result = a | b;
        OpAddi:  result = addr;
        OpLoad:  result = mem[addr[3:0]];
        OpStore:
        begin
          // Data comes from rd, low four address bits pick the word
          mem[addr[3:0]] = d;
          writes = 1'b0;
        end
        OpBeq:
        begin
          if (d == a)
            nextPc = pc + int'($signed(immV));
          writes = 1'b0;
        end
        default: writes = 1'b0;
      endcase
      if (writes)
      begin
        // The retire port shows r0 writes, the register keeps zero
        expectRetire(rd, result, progName[pc]);
        if (rd != 3'd0)
          regs[rd] = result;
      end
      pc = nextPc;
      steps++;
    end
  endtask

  task automatic checkRetire(input int idx);
    if (retireDest !== expDest[idx] || retireData !== expData[idx])
    begin
      checkErrors++;
      $display("CHECK FAILED %s retire %0d: expected r%0d=%h, actual r%0d=%h",
               expName[idx], idx, expDest[idx], expData[idx], retireDest, retireData);
    end
  endtask

  // Directed rows, then random ALU rows
  task automatic buildProgram();
    int sel;
    opcodeT op;
    // Back-to-back dependencies through memory forwarding
    addRow(immInstr(OpAddi, 1, 0, 5), "mem_forward");
    addRow(immInstr(OpAddi, 2, 1, 3), "mem_forward");
    addRow(regInstr(OpAdd, 3, 2, 1), "mem_forward");
    // Two apart uses writeback, three apart uses write-through
    addRow(immInstr(OpAddi, 4, 0, 10), "wb_forward");
    addRow(regInstr(OpNop, 0, 0, 0), "wb_forward");
    addRow(regInstr(OpAdd, 5, 4, 4), "wb_forward");
    addRow(immInstr(OpAddi, 6, 0, 7), "wb_forward");
    addRow(regInstr(OpNop, 0, 0, 0), "wb_forward");
    addRow(regInstr(OpNop, 0, 0, 0), "wb_forward");
    addRow(regInstr(OpSub, 7, 6, 3), "wb_forward");
    // Store then load, each load used right away
    addRow(immInstr(OpAddi, 1, 0, 42), "load_use");
    addRow(immInstr(OpStore, 1, 0, 3), "load_use");
    addRow(immInstr(OpLoad, 2, 0, 3), "load_use");
    addRow(regInstr(OpAdd, 3, 2, 1), "load_use");
    addRow(immInstr(OpLoad, 4, 0, 3), "load_use");
    addRow(immInstr(OpAddi, 4, 4, 1), "load_use");
    // Taken beq skips two rows, the second beq falls through
    addRow(immInstr(OpBeq, 1, 1, 3), "branch");
    addRow(immInstr(OpAddi, 5, 0, 99), "branch");
    addRow(immInstr(OpAddi, 6, 0, 99), "branch");
    addRow(immInstr(OpAddi, 5, 5, 1), "branch");
    addRow(immInstr(OpBeq, 5, 0, 5), "branch");
    addRow(immInstr(OpAddi, 6, 0, 11), "branch");
    addRow(immInstr(OpAddi, 7, 0, 12), "branch");
    // r0 swallows writes
    addRow(immInstr(OpAddi, 0, 0, 55), "r0_write");
    addRow(regInstr(OpAdd, 1, 0, 0), "r0_write");
    addRow(immInstr(OpAddi, 2, 0, 4), "r0_write");
    for (int n = 0; n < 20; n++)
    begin
      sel = $unsigned($random(seed)) % 5;
      case (sel)
        0:       op = OpAdd;
        1:       op = OpSub;
        2:       op = OpAnd;
        3:       op = OpOr;
        default: op = OpAddi;
      endcase
      if (op == OpAddi)
        addRow(immInstr(op, $random(seed) & 7, $random(seed) & 7, $random(seed)),
               "random_alu");
      else
        addRow(regInstr(op, $random(seed) & 7, $random(seed) & 7, $random(seed) & 7),
               "random_alu");
    end
  endtask

  // Answer fetch a little after each edge
  initial
  begin
    instrF = '0;
    forever
    begin
      @(posedge clk);
      #2;
      instrF = fetchWord(pcF);
    end
  end

  // Watchdog sized by the program length
  initial
  begin
    wait (tableReady);
    repeat (16 + 2 * progLen + 50) @(posedge clk);
    $display("Run timed out: expected retires never all arrived");
    $display("Errors: %0d value mismatches, %0d other failures", checkErrors, otherErrors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    reset       = 1'b1;
    checkErrors = 0;
    otherErrors = 0;
    progLen     = 0;
    expCount    = 0;
    seed        = 32'h94e3_838d;
    buildProgram();
    runReferenceModel();
    tableReady = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    // Retires are checked mid-cycle, in order
    for (int i = 0; i < expCount; i++)
    begin
      @(negedge clk);
      while (!retireValid)
        @(negedge clk);
      checkRetire(i);
    end
    // Nothing may retire once the program has drained
    repeat (10)
    begin
      @(negedge clk);
      if (retireValid)
      begin
        otherErrors++;
        $display("Unexpected retire of r%0d = %h after the last expected one",
                 retireDest, retireData);
      end
    end
    $display("Errors: %0d value mismatches, %0d other failures", checkErrors, otherErrors);
    if (checkErrors == 0 && otherErrors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
